// File: design/bru_consts.svh
`ifndef BRU_CONSTS_SVH
`define BRU_CONSTS_SVH

// Datapath width
`define BRU_XLEN 32

// Physical register id width, 64 registers
`define BRU_RNID_W 6

// Branch tags in flight, also the branch mask width
`define BRU_BRTAG_W 4

// Write-back buses into the register file
`define BRU_TGT_BUS_NUM 2

// One-hot reservation-station index
`define BRU_INDEX_W 8

`endif

// File: design/bru_decoder.sv
`timescale 1ns/1ps

module bru_decoder (
  input  logic [31:0]         i_inst,
  output bru_pkg::pipe_ctrl_t o_ctrl
);

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_ctrl.op    = bru_pkg::OP_EQ;
    o_ctrl.imm   = bru_pkg::IMM_SB;
    o_ctrl.wr_rd = 1'b0;
    case (w_opcode)
      7'b1101111: begin  // JAL
        o_ctrl.op    = bru_pkg::OP_JUMP;
        o_ctrl.imm   = bru_pkg::IMM_UJ;
        o_ctrl.wr_rd = 1'b1;
      end
      7'b1100111: begin  // JALR
        o_ctrl.op    = bru_pkg::OP_JUMP;
        o_ctrl.imm   = bru_pkg::IMM_I;
        o_ctrl.wr_rd = 1'b1;
      end
      7'b1100011: begin
        case (w_funct3)
          3'b001:  o_ctrl.op = bru_pkg::OP_NE;
          3'b100:  o_ctrl.op = bru_pkg::OP_LT;
          3'b101:  o_ctrl.op = bru_pkg::OP_GE;
          3'b110:  o_ctrl.op = bru_pkg::OP_LTU;
          3'b111:  o_ctrl.op = bru_pkg::OP_GEU;
          default: o_ctrl.op = bru_pkg::OP_EQ;
        endcase
      end
      default: o_ctrl.op = bru_pkg::OP_EQ;
    endcase
  end

endmodule

// File: design/bru_issue_stage.sv
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_issue_stage (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  bru_pkg::issue_t      i_issue,
  input  logic                 i_commit_flush,
  input  bru_pkg::br_upd_t     i_br_upd,
  output bru_pkg::regread_t    o_rd [2],
  input  logic [`BRU_XLEN-1:0] i_rd_data [2],
  output bru_pkg::ex2_pkt_t    o_ex2
);

  bru_pkg::pipe_ctrl_t w_ex0_ctrl;
  logic                w_ex0_kill;
  bru_pkg::issue_t     r_ex1_issue;
  bru_pkg::pipe_ctrl_t r_ex1_ctrl;
  logic                r_ex1_dead;
  logic                w_ex1_kill;

  bru_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  assign w_ex0_kill = i_issue.valid &
                      bru_pkg::br_kill(i_issue.br_mask, i_br_upd, i_commit_flush);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex1_dead  <= 1'b0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex1_dead  <= w_ex0_kill;
    end
  end

  // Register-file read in EX1
  assign o_rd[0].valid = r_ex1_issue.valid & r_ex1_issue.rs1_valid;
  assign o_rd[0].rnid  = r_ex1_issue.rs1_rnid;
  assign o_rd[1].valid = r_ex1_issue.valid & r_ex1_issue.rs2_valid;
  assign o_rd[1].rnid  = r_ex1_issue.rs2_rnid;

  assign w_ex1_kill = r_ex1_issue.valid &
                      bru_pkg::br_kill(r_ex1_issue.br_mask, i_br_upd, i_commit_flush);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2 <= '0;
    end else begin
      o_ex2.issue     <= r_ex1_issue;
      o_ex2.pipe_ctrl <= r_ex1_ctrl;
      o_ex2.dead      <= r_ex1_dead | w_ex1_kill;  // Sticky
      o_ex2.rs1_data  <= i_rd_data[0];
      o_ex2.rs2_data  <= i_rd_data[1];
    end
  end

endmodule

// File: design/bru_operand_stage.sv
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_operand_stage (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  bru_pkg::ex2_pkt_t i_ex2,
  input  bru_pkg::phy_wr_t  i_tgt_bus [`BRU_TGT_BUS_NUM],
  input  bru_pkg::br_upd_t  i_br_upd,
  input  logic              i_commit_flush,
  output bru_pkg::ex3_pkt_t o_ex3
);

  logic [`BRU_TGT_BUS_NUM-1:0] w_rs1_hit;
  logic [`BRU_TGT_BUS_NUM-1:0] w_rs2_hit;
  logic [`BRU_XLEN-1:0]        w_rs1;
  logic [`BRU_XLEN-1:0]        w_rs2;
  logic                        w_result;
  logic [`BRU_XLEN-1:0]        w_off_sb;
  logic [`BRU_XLEN-1:0]        w_off_uj;
  logic [`BRU_XLEN-1:0]        w_off_i;
  logic [`BRU_XLEN-1:0]        w_target;
  logic                        w_kill;

  function automatic logic fwd_match(
    input logic                   src_valid,
    input logic [`BRU_RNID_W-1:0] src_rnid,
    input bru_pkg::phy_wr_t       bus
  );
    return src_valid & bus.valid & (bus.rd_rnid == src_rnid) & (src_rnid != '0);
  endfunction

  for (genvar b = 0; b < `BRU_TGT_BUS_NUM; b++) begin : g_fwd
    assign w_rs1_hit[b] = fwd_match(i_ex2.issue.rs1_valid, i_ex2.issue.rs1_rnid, i_tgt_bus[b]);
    assign w_rs2_hit[b] = fwd_match(i_ex2.issue.rs2_valid, i_ex2.issue.rs2_rnid, i_tgt_bus[b]);
  end

  // Writes landing in EX2 missed the register read
  always_comb begin
    w_rs1 = i_ex2.rs1_data;
    w_rs2 = i_ex2.rs2_data;
    for (int b = 0; b < `BRU_TGT_BUS_NUM; b++) begin
      if (w_rs1_hit[b]) begin
        w_rs1 = i_tgt_bus[b].rd_data;
      end
      if (w_rs2_hit[b]) begin
        w_rs2 = i_tgt_bus[b].rd_data;
      end
    end
  end

  always_comb begin
    case (i_ex2.pipe_ctrl.op)
      bru_pkg::OP_EQ:  w_result = (w_rs1 == w_rs2);
      bru_pkg::OP_NE:  w_result = (w_rs1 != w_rs2);
      bru_pkg::OP_LT:  w_result = ($signed(w_rs1) < $signed(w_rs2));
      bru_pkg::OP_GE:  w_result = ($signed(w_rs1) >= $signed(w_rs2));
      bru_pkg::OP_LTU: w_result = (w_rs1 < w_rs2);
      bru_pkg::OP_GEU: w_result = (w_rs1 >= w_rs2);
      default:         w_result = 1'b1;  // Jumps always taken
    endcase
  end

  assign w_off_sb = {{(`BRU_XLEN-13){i_ex2.issue.inst[31]}}, i_ex2.issue.inst[31],
                     i_ex2.issue.inst[7], i_ex2.issue.inst[30:25], i_ex2.issue.inst[11:8], 1'b0};
  assign w_off_uj = {{(`BRU_XLEN-21){i_ex2.issue.inst[31]}}, i_ex2.issue.inst[31],
                     i_ex2.issue.inst[19:12], i_ex2.issue.inst[20], i_ex2.issue.inst[30:21], 1'b0};
  assign w_off_i  = {{(`BRU_XLEN-12){i_ex2.issue.inst[31]}}, i_ex2.issue.inst[31:20]};

  always_comb begin
    case (i_ex2.pipe_ctrl.imm)
      bru_pkg::IMM_UJ: w_target = i_ex2.issue.pc + w_off_uj;
      bru_pkg::IMM_I:  w_target = (w_rs1 + w_off_i) & ~`BRU_XLEN'(1);  // JALR clears bit 0
      default:         w_target = i_ex2.issue.pc + w_off_sb;
    endcase
  end

  assign w_kill = i_ex2.issue.valid &
                  bru_pkg::br_kill(i_ex2.issue.br_mask, i_br_upd, i_commit_flush);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex3 <= '0;
    end else begin
      o_ex3.issue  <= i_ex2.issue;
      o_ex3.wr_rd  <= i_ex2.pipe_ctrl.wr_rd;
      o_ex3.result <= w_result;
      o_ex3.target <= w_target;
      o_ex3.dead   <= i_ex2.dead | w_kill;
    end
  end

  a_fwd_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex2.issue.valid |-> ($onehot0(w_rs1_hit) && $onehot0(w_rs2_hit)))
    else $error("more than one bus forwards to an operand");

endmodule

// File: design/bru_phys_regfile.sv
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_phys_regfile (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  bru_pkg::phy_wr_t     i_tgt_bus [`BRU_TGT_BUS_NUM],
  input  bru_pkg::regread_t    i_rd [2],
  output logic [`BRU_XLEN-1:0] o_rd_data [2]
);

  logic [`BRU_XLEN-1:0] r_regs [1 << `BRU_RNID_W];
  logic                 w_dup_wr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < (1 << `BRU_RNID_W); r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int b = 0; b < `BRU_TGT_BUS_NUM; b++) begin
        if (i_tgt_bus[b].valid && i_tgt_bus[b].rd_rnid != '0) begin
          r_regs[i_tgt_bus[b].rd_rnid] <= i_tgt_bus[b].rd_data;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      o_rd_data[p] = r_regs[i_rd[p].rnid];
      for (int b = 0; b < `BRU_TGT_BUS_NUM; b++) begin
        if (i_tgt_bus[b].valid && i_tgt_bus[b].rd_rnid == i_rd[p].rnid) begin
          o_rd_data[p] = i_tgt_bus[b].rd_data;  // Later bus wins
        end
      end
      if (!i_rd[p].valid || i_rd[p].rnid == '0) begin
        o_rd_data[p] = '0;
      end
    end
  end

  always_comb begin
    w_dup_wr = 1'b0;
    for (int a = 0; a < `BRU_TGT_BUS_NUM; a++) begin
      for (int b = a + 1; b < `BRU_TGT_BUS_NUM; b++) begin
        if (i_tgt_bus[a].valid && i_tgt_bus[b].valid &&
            i_tgt_bus[a].rd_rnid == i_tgt_bus[b].rd_rnid && i_tgt_bus[a].rd_rnid != '0) begin
          w_dup_wr = 1'b1;
        end
      end
    end
  end

  // Renaming hands out each id once, so two producers never share a cycle
  a_no_dup_wr: assert property (@(posedge i_clk) disable iff (!i_reset_n) !w_dup_wr)
    else $error("two buses write the same physical register");

endmodule

// File: design/bru_pkg.sv
`include "bru_consts.svh"

package bru_pkg;

  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,
    OP_GE,
    OP_LTU,
    OP_GEU,
    OP_JUMP
  } op_t;

  typedef enum logic [1:0] {
    IMM_SB,
    IMM_UJ,
    IMM_I
  } imm_t;

  typedef logic [$clog2(`BRU_BRTAG_W)-1:0] brtag_t;

  typedef struct packed {
    op_t  op;
    imm_t imm;
    logic wr_rd;  // Link register write
  } pipe_ctrl_t;

  typedef struct packed {
    logic                     valid;
    logic [31:0]              inst;
    logic [`BRU_XLEN-1:0]     pc;
    logic                     rs1_valid;
    logic [`BRU_RNID_W-1:0]   rs1_rnid;
    logic                     rs2_valid;
    logic [`BRU_RNID_W-1:0]   rs2_rnid;
    logic [4:0]               rd_regidx;
    logic [`BRU_RNID_W-1:0]   rd_rnid;
    brtag_t                   brtag;
    logic [`BRU_BRTAG_W-1:0]  br_mask;  // Older branches this one depends on
    logic                     pred_taken;
    logic                     btb_valid;
    logic [`BRU_XLEN-1:0]     btb_target;
    logic [`BRU_INDEX_W-1:0]  index;
  } issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`BRU_RNID_W-1:0] rd_rnid;
    logic [`BRU_XLEN-1:0]   rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic                   valid;
    logic [`BRU_RNID_W-1:0] rnid;
  } regread_t;

  typedef struct packed {
    logic                    update;
    logic                    taken;
    logic                    mispredict;
    logic                    dead;
    logic [`BRU_XLEN-1:0]    pc;
    logic [`BRU_XLEN-1:0]    target;
    brtag_t                  brtag;
    logic [`BRU_BRTAG_W-1:0] br_mask;
  } br_upd_t;

  typedef struct packed {
    logic                    done;
    logic [`BRU_INDEX_W-1:0] index;
  } done_t;

  typedef struct packed {
    issue_t               issue;
    pipe_ctrl_t           pipe_ctrl;
    logic                 dead;
    logic [`BRU_XLEN-1:0] rs1_data;
    logic [`BRU_XLEN-1:0] rs2_data;
  } ex2_pkt_t;

  typedef struct packed {
    issue_t               issue;
    logic                 wr_rd;
    logic                 result;   // Branch taken
    logic [`BRU_XLEN-1:0] target;
    logic                 dead;
  } ex3_pkt_t;

  // Kill check shared by EX0, EX1 and EX2
  function automatic logic br_kill(
    input logic [`BRU_BRTAG_W-1:0] br_mask,
    input br_upd_t                 upd,
    input logic                    commit_flush
  );
    return commit_flush |
           (upd.update & upd.mispredict & ~upd.dead & br_mask[upd.brtag]);
  endfunction

endpackage

// File: design/bru_resolve.sv
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_resolve (
  input  bru_pkg::ex3_pkt_t i_ex3,
  output bru_pkg::phy_wr_t  o_phy_wr,
  output bru_pkg::done_t    o_done,
  output bru_pkg::br_upd_t  o_br_upd
);

  logic [`BRU_XLEN-1:0] w_next_pc;
  logic                 w_mispredict;

  assign w_next_pc = i_ex3.issue.pc + `BRU_XLEN'(4);

  // BTB miss predicts fall-through
  assign w_mispredict = (~i_ex3.issue.btb_valid & i_ex3.result) |
                        (i_ex3.issue.btb_valid &
                         ((i_ex3.result != i_ex3.issue.pred_taken) |
                          (i_ex3.result & i_ex3.issue.pred_taken &
                           (i_ex3.target != i_ex3.issue.btb_target))));

  assign o_done.done  = i_ex3.issue.valid;
  assign o_done.index = i_ex3.issue.index;

  assign o_phy_wr.valid   = i_ex3.issue.valid & i_ex3.wr_rd &
                            (i_ex3.issue.rd_regidx != '0) & ~i_ex3.dead;
  assign o_phy_wr.rd_rnid = i_ex3.issue.rd_rnid;
  assign o_phy_wr.rd_data = w_next_pc;  // Link value

  assign o_br_upd.update     = i_ex3.issue.valid;
  assign o_br_upd.taken      = i_ex3.result;
  assign o_br_upd.mispredict = w_mispredict;
  assign o_br_upd.dead       = i_ex3.dead;
  assign o_br_upd.pc         = i_ex3.issue.pc;
  assign o_br_upd.target     = i_ex3.result ? i_ex3.target : w_next_pc;
  assign o_br_upd.brtag      = i_ex3.issue.brtag;
  assign o_br_upd.br_mask    = i_ex3.issue.br_mask;

endmodule

// File: design/bru_top.sv
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_top (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  bru_pkg::issue_t  i_issue,
  input  bru_pkg::phy_wr_t i_tgt_bus [`BRU_TGT_BUS_NUM],
  input  logic             i_commit_flush,
  output bru_pkg::phy_wr_t o_phy_wr,
  output bru_pkg::done_t   o_done,
  output bru_pkg::br_upd_t o_br_upd
);

  bru_pkg::regread_t    w_rd [2];
  logic [`BRU_XLEN-1:0] w_rd_data [2];
  bru_pkg::ex2_pkt_t    w_ex2;
  bru_pkg::ex3_pkt_t    w_ex3;

  bru_phys_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_tgt_bus (i_tgt_bus),
    .i_rd      (w_rd),
    .o_rd_data (w_rd_data)
  );

  bru_issue_stage u_issue (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue        (i_issue),
    .i_commit_flush (i_commit_flush),
    .i_br_upd       (o_br_upd),
    .o_rd           (w_rd),
    .i_rd_data      (w_rd_data),
    .o_ex2          (w_ex2)
  );

  bru_operand_stage u_operand (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex2          (w_ex2),
    .i_tgt_bus      (i_tgt_bus),
    .i_br_upd       (o_br_upd),
    .i_commit_flush (i_commit_flush),
    .o_ex3          (w_ex3)
  );

  bru_resolve u_resolve (
    .i_ex3    (w_ex3),
    .o_phy_wr (o_phy_wr),
    .o_done   (o_done),
    .o_br_upd (o_br_upd)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the branch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --timescale 1ns/1ps -f sim.f --top-module tb_bru_top \
  -o tb_bru_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_bru_top > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation reported no result"; exit 1; }
echo "simulation passed"

// File: sim.f
+incdir+design
+incdir+tb
design/bru_pkg.sv
design/bru_decoder.sv
design/bru_phys_regfile.sv
design/bru_issue_stage.sv
design/bru_operand_stage.sv
design/bru_resolve.sv
design/bru_top.sv
tb/tb_bru_top.sv

// File: tb/bru_model.svh
`ifndef BRU_MODEL_SVH
`define BRU_MODEL_SVH

typedef struct packed {
  bru_pkg::done_t   done;
  bru_pkg::br_upd_t upd;
  bru_pkg::phy_wr_t wr;
} exp_t;

logic [31:0]          lfsr_state = 32'hccc7_5e3f;
logic [`BRU_XLEN-1:0] shadow [1 << `BRU_RNID_W];
bru_pkg::issue_t      pipe_issue [3];  // EX0, EX1, EX2
logic                 pipe_dead [3];
exp_t                 exp_q [$];

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    v = {v[30:0], fb};
  end
  return v;
endfunction

function automatic logic [`BRU_XLEN-1:0] read_shadow(input logic valid,
                                                     input logic [`BRU_RNID_W-1:0] rnid);
  return (valid && rnid != '0) ? shadow[rnid] : '0;
endfunction

function automatic logic branch_taken(input logic [31:0] inst,
                                      input logic [`BRU_XLEN-1:0] a,
                                      input logic [`BRU_XLEN-1:0] b);
  if (inst[6:0] != 7'b1100011) begin
    return 1'b1;  // JAL, JALR
  end
  case (inst[14:12])
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return {~a[31], a[30:0]} < {~b[31], b[30:0]};  // Signed via biased compare
    3'b101:  return {~a[31], a[30:0]} >= {~b[31], b[30:0]};
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

function automatic logic [`BRU_XLEN-1:0] calc_target(input logic [31:0] inst,
                                                     input logic [`BRU_XLEN-1:0] pc,
                                                     input logic [`BRU_XLEN-1:0] a);
  logic [`BRU_XLEN-1:0] imm;
  case (inst[6:0])
    7'b1101111: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    7'b1100111: return (a + {{20{inst[31]}}, inst[31:20]}) & 32'hffff_fffe;
    default:    imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  endcase
  return pc + imm;
endfunction

// EX3 outputs for the branch in EX2, shadow already holds the EX2 bus writes
function automatic exp_t expect_out(input bru_pkg::issue_t iss, input logic dead);
  exp_t                 e;
  logic [`BRU_XLEN-1:0] a;
  logic [`BRU_XLEN-1:0] tgt;
  logic [`BRU_XLEN-1:0] link;
  logic                 taken;
  e = '0;
  if (!iss.valid) begin
    return e;
  end
  a     = read_shadow(iss.rs1_valid, iss.rs1_rnid);
  taken = branch_taken(iss.inst, a, read_shadow(iss.rs2_valid, iss.rs2_rnid));
  tgt   = calc_target(iss.inst, iss.pc, a);
  link  = iss.pc + 32'd4;
  e.done.done      = 1'b1;
  e.done.index     = iss.index;
  e.upd.update     = 1'b1;
  e.upd.taken      = taken;
  e.upd.mispredict = iss.btb_valid ? (taken != iss.pred_taken ||
                                      (taken && tgt != iss.btb_target)) : taken;
  e.upd.dead       = dead;
  e.upd.pc         = iss.pc;
  e.upd.target     = taken ? tgt : link;
  e.upd.brtag      = iss.brtag;
  e.upd.br_mask    = iss.br_mask;
  e.wr.valid       = iss.inst[6:2] == 5'b11011 || iss.inst[6:0] == 7'b1100111;
  e.wr.valid       = e.wr.valid && iss.rd_regidx != '0 && !dead;
  e.wr.rd_rnid     = iss.rd_rnid;
  e.wr.rd_data     = link;
  return e;
endfunction

task automatic reset_model();
  for (int r = 0; r < (1 << `BRU_RNID_W); r++) begin
    shadow[r] = '0;
  end
  for (int s = 0; s < 3; s++) begin
    pipe_issue[s] = '0;
    pipe_dead[s]  = 1'b0;
  end
  exp_q.delete();
endtask

// One clock of the pipe, with the inputs and update seen up to the next rising edge
task automatic advance_pipe(input bru_pkg::issue_t iss,
                            input bru_pkg::phy_wr_t bus [`BRU_TGT_BUS_NUM],
                            input logic flush,
                            input bru_pkg::br_upd_t upd);
  pipe_issue[0] = iss;
  pipe_dead[0]  = 1'b0;
  for (int s = 0; s < 3; s++) begin
    if (pipe_issue[s].valid && (flush || (upd.update && upd.mispredict && !upd.dead &&
        pipe_issue[s].br_mask[upd.brtag]))) begin
      pipe_dead[s] = 1'b1;
    end
  end
  for (int b = 0; b < `BRU_TGT_BUS_NUM; b++) begin
    if (bus[b].valid && bus[b].rd_rnid != '0) begin
      shadow[bus[b].rd_rnid] = bus[b].rd_data;
    end
  end
  exp_q.push_back(expect_out(pipe_issue[2], pipe_dead[2]));
  pipe_issue[2] = pipe_issue[1];
  pipe_dead[2]  = pipe_dead[1];
  pipe_issue[1] = pipe_issue[0];
  pipe_dead[1]  = pipe_dead[0];
endtask

`endif

// File: tb/tb_bru_top.sv
`timescale 1ns/1ps
`include "bru_consts.svh"

module tb_bru_top;

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_CYCLES  = 400;
  localparam int WATCHDOG_NS = (NUM_CYCLES + 3 + 4) * CLK_PERIOD * 2;

  logic              clk;
  logic              reset_n;
  bru_pkg::issue_t   issue;
  bru_pkg::phy_wr_t  tgt_bus [`BRU_TGT_BUS_NUM];
  logic              commit_flush;
  bru_pkg::phy_wr_t  phy_wr;
  bru_pkg::done_t    done;
  bru_pkg::br_upd_t  br_upd;
  int                err_done = 0;
  int                err_upd = 0;
  int                err_wr = 0;
  int                err_idle = 0;

  `include "bru_model.svh"

  bru_top i_dut (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_issue        (issue),
    .i_tgt_bus      (tgt_bus),
    .i_commit_flush (commit_flush),
    .o_phy_wr       (phy_wr),
    .o_done         (done),
    .o_br_upd       (br_upd)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [`BRU_XLEN-1:0] pick_data();
    case (rand_bits(3))
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h7fff_ffff;  // Signed edges
      3:       return 32'h8000_0000;
      4:       return 32'hffff_ffff;
      default: return rand_bits(32);
    endcase
  endfunction

  task automatic drive_inputs(input logic active);
    bru_pkg::issue_t iss;
    logic [2:0]      kind;
    for (int b = 0; b < `BRU_TGT_BUS_NUM; b++) begin
      tgt_bus[b].valid   = active && rand_bits(1) != 0;
      tgt_bus[b].rd_rnid = 6'(rand_bits(3));  // Small id range so buses hit sources
      tgt_bus[b].rd_data = pick_data();
      for (int a = 0; a < b; a++) begin
        if (tgt_bus[a].rd_rnid == tgt_bus[b].rd_rnid) begin
          tgt_bus[b].valid = 1'b0;
        end
      end
    end
    kind = 3'(rand_bits(3));
    iss.valid = active && rand_bits(2) != 0;
    iss.inst  = rand_bits(32);
    if (kind == 3'd6) begin
      iss.inst[6:0] = 7'b1101111;
    end else if (kind == 3'd7) begin
      iss.inst[6:0]   = 7'b1100111;
      iss.inst[14:12] = 3'b000;
    end else begin
      iss.inst[6:0]   = 7'b1100011;
      iss.inst[14:12] = (kind < 3'd2) ? kind : {1'b1, 2'(kind - 3'd2)};
    end
    iss.pc         = rand_bits(32) & ~32'h3;
    iss.rs1_valid  = rand_bits(3) != 0;
    iss.rs1_rnid   = 6'(rand_bits(3));
    iss.rs2_valid  = rand_bits(3) != 0;
    iss.rs2_rnid   = 6'(rand_bits(3));
    iss.rd_regidx  = (rand_bits(3) == 0) ? 5'd0 : 5'(rand_bits(5));
    iss.rd_rnid    = 6'(rand_bits(6));
    iss.brtag      = bru_pkg::brtag_t'(rand_bits(2));
    iss.br_mask    = 4'(rand_bits(4) & rand_bits(4));
    iss.pred_taken = rand_bits(1) != 0;
    iss.btb_valid  = rand_bits(1) != 0;
    iss.btb_target = (rand_bits(1) != 0) ?
                     calc_target(iss.inst, iss.pc, read_shadow(iss.rs1_valid, iss.rs1_rnid)) :
                     rand_bits(32);
    iss.index      = 8'(1) << rand_bits(3);
    issue          = iss;
    commit_flush   = active && rand_bits(5) == 0;
  endtask

  task automatic verify_idle();
    assert (!done.done && !br_upd.update && !phy_wr.valid) else begin
      err_idle++;
      $display("error %0d ns: output strobe high with no branch in EX3", $time);
    end
  endtask

  task automatic compare_outputs(input exp_t e);
    if (!e.done.done) begin
      verify_idle();
    end else begin
      assert (done === e.done) else begin
        err_done++;
        $display("error %0d ns: done %h, expected %h", $time, done, e.done);
      end
      assert (br_upd === e.upd) else begin
        err_upd++;
        $display("error %0d ns: branch update %h, expected %h", $time, br_upd, e.upd);
      end
      assert (phy_wr.valid === e.wr.valid && (!e.wr.valid || phy_wr === e.wr)) else begin
        err_wr++;
        $display("error %0d ns: link write %h, expected %h", $time, phy_wr, e.wr);
      end
    end
  endtask

  initial begin
    bru_pkg::br_upd_t upd_seen;
    clk          = 1'b0;
    reset_n      = 1'b0;
    commit_flush = 1'b0;
    issue        = '0;
    for (int b = 0; b < `BRU_TGT_BUS_NUM; b++) begin
      tgt_bus[b] = '0;
    end
    reset_model();
    repeat (3) begin
      @(negedge clk);
      verify_idle();
    end
    reset_n = 1'b1;
    for (int cyc = 0; cyc < NUM_CYCLES + 4; cyc++) begin
      @(negedge clk);
      if (exp_q.size() > 0) begin
        compare_outputs(exp_q.pop_front());
      end else begin
        verify_idle();
      end
      upd_seen = br_upd;  // Update seen by the kill logic this cycle
      drive_inputs(cyc < NUM_CYCLES);
      advance_pipe(issue, tgt_bus, commit_flush, upd_seen);
    end
    $display("summary: %0d cycles, errors done %0d, update %0d, link write %0d, idle %0d",
             NUM_CYCLES, err_done, err_upd, err_wr, err_idle);
    if (err_done + err_upd + err_wr + err_idle == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule
